// ==== files.f ====
src/bus_map_pkg.sv
src/tacho_pkg.sv
src/local_bus_sync.sv
src/tacho_regs.sv
src/tacho_pair.sv
src/sim_db_top.sv
tests/tb_sim_db.sv

// ==== src/bus_map_pkg.sv ====
`default_nettype none

package bus_map_pkg;

  typedef logic [11:0] addr_t;      // local bus address
  typedef logic [15:0] reg_word_t;  // local bus data word

  localparam logic [3:0] region_fpga = 4'h8;  // device answers 0x8xx only

  localparam reg_word_t version_word  = 16'hB626;
  localparam reg_word_t pat_aaaa_word = 16'hAAAA;
  localparam reg_word_t pat_5555_word = 16'h5555;
  localparam reg_word_t pat_ffff_word = 16'hFFFF;
  localparam reg_word_t pat_0000_word = 16'h0000;

  // ---------------------------------------------------------
  // register map
  localparam addr_t addr_version    = 12'h800;
  localparam addr_t addr_pat_aaaa   = 12'h802;
  localparam addr_t addr_pat_5555   = 12'h804;
  localparam addr_t addr_pat_ffff   = 12'h806;
  localparam addr_t addr_pat_0000   = 12'h808;
  localparam addr_t addr_mode       = 12'h810;  // bit n: pair n limited
  localparam addr_t addr_out_ctrl   = 12'h812;  // bits 2n, 2n+1: channel enables
  localparam addr_t addr_load       = 12'h814;  // bit n: restart on 0->1
  localparam addr_t addr_freq_base  = 12'h820;  // lo at +4n, hi at +4n+2
  localparam addr_t addr_phase_base = 12'h840;  // same layout as freq
  localparam addr_t addr_pulse_base = 12'h860;  // pair n at +2n
  localparam addr_t addr_finished   = 12'h870;  // read only

endpackage

`default_nettype wire

// ==== src/local_bus_sync.sv ====
`default_nettype none
`timescale 1ns/1ns

module local_bus_sync (
  input  wire                          W_clk,
  input  wire                          W_reset_n,
  input  wire  bus_map_pkg::addr_t     la,
  input  wire                          lcs_n,
  input  wire                          lrd_n,
  input  wire                          lwr_n,
  input  wire  bus_map_pkg::reg_word_t rd_data,
  output logic                         rd_stb,
  output logic                         wr_stb,
  output bus_map_pkg::reg_word_t       ld_out,
  output logic                         ld_oe
);

  logic cs_s1;
  logic cs_s2;  // synchronized chip select
  logic rd_s1;
  logic rd_s2;  // synchronized read strobe
  logic rd_s3;  // delayed copy for edge detect
  logic wr_s1;
  logic wr_s2;
  logic wr_s3;
  logic in_region;

  assign in_region = (la[11:8] == bus_map_pkg::region_fpga);

  // ---------------------------------------------------------
  // two-stage sync, then falling edge detect
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      cs_s1  <= 1'b1;
      cs_s2  <= 1'b1;
      rd_s1  <= 1'b1;
      rd_s2  <= 1'b1;
      rd_s3  <= 1'b1;
      wr_s1  <= 1'b1;
      wr_s2  <= 1'b1;
      wr_s3  <= 1'b1;
      rd_stb <= 1'b0;
      wr_stb <= 1'b0;
    end
    else
    begin
      cs_s1  <= lcs_n;
      cs_s2  <= cs_s1;
      rd_s1  <= lrd_n;
      rd_s2  <= rd_s1;
      rd_s3  <= rd_s2;
      wr_s1  <= lwr_n;
      wr_s2  <= wr_s1;
      wr_s3  <= wr_s2;
      rd_stb <= !cs_s2 && in_region && !rd_s2 && rd_s3;  // one clock per read
      wr_stb <= !cs_s2 && in_region && !wr_s2 && wr_s3;
    end
  end

  // drive window covers the read strobe plus one clock
  assign ld_oe  = !cs_s2 && in_region && (!rd_s2 || !rd_s3);
  assign ld_out = ld_oe ? rd_data : '0;

endmodule

`default_nettype wire

// ==== src/sim_db_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module sim_db_top #(
  parameter int num_pairs = 2  // 1 to 6
) (
  input  wire                          W_clk,
  input  wire                          W_reset_n,
  input  wire  bus_map_pkg::addr_t     la,
  input  wire                          lcs_n,
  input  wire                          lrd_n,
  input  wire                          lwr_n,
  input  wire  bus_map_pkg::reg_word_t ld_in,
  output wire  bus_map_pkg::reg_word_t ld_out,
  output wire                          ld_oe,
  output wire  [2*num_pairs-1:0]       spd_ch  // two channels per pair
);

  logic                    rd_stb;
  logic                    wr_stb;
  bus_map_pkg::reg_word_t  rd_data;
  tacho_pkg::acc_t         freq [num_pairs];
  tacho_pkg::phase_word_u  phase [num_pairs];
  tacho_pkg::pulse_cnt_t   pulse_num [num_pairs];
  logic [num_pairs-1:0]    limited;
  logic [num_pairs-1:0]    load_pulse;
  logic [2*num_pairs-1:0]  ch_en;
  wire  [num_pairs-1:0]    finished;

  // ---------------------------------------------------------
  // bus front end and register file
  local_bus_sync u_bus (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (la),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .rd_data   (rd_data),
    .rd_stb    (rd_stb),
    .wr_stb    (wr_stb),
    .ld_out    (ld_out),
    .ld_oe     (ld_oe)
  );

  tacho_regs #(
    .num_pairs (num_pairs)
  ) u_regs (
    .W_clk      (W_clk),
    .W_reset_n  (W_reset_n),
    .la         (la),
    .ld_in      (ld_in),
    .rd_stb     (rd_stb),
    .wr_stb     (wr_stb),
    .rd_data    (rd_data),
    .freq       (freq),
    .phase      (phase),
    .pulse_num  (pulse_num),
    .limited    (limited),
    .load_pulse (load_pulse),
    .ch_en      (ch_en),
    .finished   (finished)
  );

  // ---------------------------------------------------------
  // one generator per channel pair
  for (genvar g = 0; g < num_pairs; g++)
  begin : g_pair
    tacho_pair u_pair (
      .W_clk      (W_clk),
      .W_reset_n  (W_reset_n),
      .freq       (freq[g]),
      .phase      (phase[g]),
      .pulse_num  (pulse_num[g]),
      .limited    (limited[g]),
      .load_pulse (load_pulse[g]),
      .ch_en      (ch_en[2*g+1:2*g]),
      .ch         (spd_ch[2*g+1:2*g]),
      .finished   (finished[g])
    );
  end

endmodule

`default_nettype wire

// ==== src/tacho_pair.sv ====
`default_nettype none
`timescale 1ns/1ns

module tacho_pair (
  input  wire                          W_clk,
  input  wire                          W_reset_n,
  input  wire  tacho_pkg::acc_t        freq,
  input  wire  tacho_pkg::phase_word_u phase,
  input  wire  tacho_pkg::pulse_cnt_t  pulse_num,
  input  wire                          limited,
  input  wire                          load_pulse,
  input  wire  [1:0]                   ch_en,
  output logic [1:0]                   ch,
  output logic                         finished
);

  tacho_pkg::acc_t       acc;
  tacho_pkg::acc_t       offset_ext;
  tacho_pkg::acc_t       ch2_acc;     // accumulator shifted by the phase offset
  tacho_pkg::pulse_cnt_t pulse_cnt;   // rising edges of channel 1
  logic                  ch1_d;
  logic                  lag_armed;
  logic                  rise;
  logic                  fall;
  logic                  run_done;

  // ---------------------------------------------------------
  // channel 2 phase
  assign offset_ext = {1'b0, phase.fields.offset};
  assign ch2_acc    = phase.fields.ch2_leads ? acc + offset_ext : acc - offset_ext;

  assign rise = acc[31] & ~ch1_d;
  assign fall = ~acc[31] & ch1_d;

  // limited run ends on the falling edge of the last pulse,
  // a count of zero ends it straight away
  assign run_done = limited &
                    ((pulse_num == '0) | (fall & (pulse_cnt >= pulse_num)));

  // ---------------------------------------------------------
  // accumulator and pulse counter
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n || load_pulse)  // load restarts from zero phase
    begin
      acc       <= '0;
      pulse_cnt <= '0;
      ch1_d     <= 1'b0;
      lag_armed <= 1'b0;
      finished  <= 1'b0;
    end
    else if (!finished)  // frozen after a limited run
    begin
      ch1_d <= acc[31];
      if (acc[31])
        lag_armed <= 1'b1;  // lagging channel may start now
      if (rise)
        pulse_cnt <= pulse_cnt + 1'b1;
      if (run_done)
        finished <= 1'b1;
      else
        acc <= acc + freq;
    end
  end

  // ---------------------------------------------------------
  // registered outputs

  // a lagging channel 2 starts out high after a load since
  // acc - offset wraps, so it stays quiet until channel 1 has
  // risen once
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      ch <= 2'b00;
    end
    else
    begin
      ch[0] <= acc[31] & ~finished & ch_en[0];
      ch[1] <= ch2_acc[31] & (phase.fields.ch2_leads | lag_armed) &
               ~finished & ch_en[1];
    end
  end

endmodule

`default_nettype wire

// ==== src/tacho_pkg.sv ====
`default_nettype none

package tacho_pkg;

  localparam int acc_w   = 32;  // accumulator and frequency word width
  localparam int pulse_w = 16;

  // ---------------------------------------------------------
  // generator types

  // accumulator gains the frequency word every clock,
  // so output frequency = f_clk * freq / 2**acc_w
  typedef logic [acc_w-1:0] acc_t;

  typedef logic [pulse_w-1:0] pulse_cnt_t;  // pulses in a limited run

  // phase register, seen either as the bus image or decoded
  typedef union packed {
    logic [acc_w-1:0] raw;        // register image, two bus halves
    struct packed {
      logic             ch2_leads;  // 1: channel 2 ahead of channel 1
      logic [acc_w-2:0] offset;     // distance as accumulator fraction
    } fields;
  } phase_word_u;

  // offset 0x4000_0000 is a quarter period
  // 31-bit offset keeps the distance below half a period

endpackage

`default_nettype wire

// ==== src/tacho_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module tacho_regs #(
  parameter int num_pairs = 2
) (
  input  wire                          W_clk,
  input  wire                          W_reset_n,
  input  wire  bus_map_pkg::addr_t     la,
  input  wire  bus_map_pkg::reg_word_t ld_in,
  input  wire                          rd_stb,
  input  wire                          wr_stb,
  output bus_map_pkg::reg_word_t       rd_data,
  output tacho_pkg::acc_t              freq [num_pairs],
  output tacho_pkg::phase_word_u       phase [num_pairs],
  output tacho_pkg::pulse_cnt_t        pulse_num [num_pairs],
  output logic [num_pairs-1:0]         limited,
  output logic [num_pairs-1:0]         load_pulse,
  output logic [2*num_pairs-1:0]       ch_en,
  input  wire  [num_pairs-1:0]         finished
);

  logic [num_pairs-1:0]   load_q;      // load register as written
  logic [num_pairs-1:0]   load_d;      // last clock's load bits
  logic [num_pairs-1:0]   finished_q;
  bus_map_pkg::reg_word_t rd_word;

  function automatic bus_map_pkg::addr_t pair_addr(bus_map_pkg::addr_t base, int offs);
    return base + bus_map_pkg::addr_t'(offs);
  endfunction

  // ---------------------------------------------------------
  // mode, output control and load
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      limited <= '0;
      ch_en   <= '0;
      load_q  <= '0;
      load_d  <= '0;
    end
    else
    begin
      load_d <= load_q;
      if (wr_stb)
      begin
        case (la)
          bus_map_pkg::addr_mode:     limited <= ld_in[num_pairs-1:0];
          bus_map_pkg::addr_out_ctrl: ch_en   <= ld_in[2*num_pairs-1:0];
          bus_map_pkg::addr_load:     load_q  <= ld_in[num_pairs-1:0];
          default: ;  // finished and unmapped ignore writes
        endcase
      end
    end
  end

  assign load_pulse = load_q & ~load_d;  // rising bits only

  // ---------------------------------------------------------
  // per-pair frequency, phase and pulse count
  for (genvar g = 0; g < num_pairs; g++)
  begin : g_pair
    localparam bus_map_pkg::addr_t freq_lo_a  = pair_addr(bus_map_pkg::addr_freq_base, 4 * g);
    localparam bus_map_pkg::addr_t freq_hi_a  = pair_addr(bus_map_pkg::addr_freq_base, 4 * g + 2);
    localparam bus_map_pkg::addr_t phase_lo_a = pair_addr(bus_map_pkg::addr_phase_base, 4 * g);
    localparam bus_map_pkg::addr_t phase_hi_a = pair_addr(bus_map_pkg::addr_phase_base, 4 * g + 2);
    localparam bus_map_pkg::addr_t pulse_a    = pair_addr(bus_map_pkg::addr_pulse_base, 2 * g);

    always_ff @(posedge W_clk)
    begin
      if (!W_reset_n)
      begin
        freq[g]      <= '0;
        phase[g].raw <= '0;
        pulse_num[g] <= '0;
      end
      else if (wr_stb)
      begin
        case (la)
          freq_lo_a:  freq[g][15:0]       <= ld_in;
          freq_hi_a:  freq[g][31:16]      <= ld_in;
          phase_lo_a: phase[g].raw[15:0]  <= ld_in;
          phase_hi_a: phase[g].raw[31:16] <= ld_in;
          pulse_a:    pulse_num[g]        <= ld_in;
          default: ;
        endcase
      end
    end
  end

  // ---------------------------------------------------------
  // read mux
  always_comb
  begin
    rd_word = '0;  // unmapped reads as zero
    case (la)
      bus_map_pkg::addr_version:  rd_word = bus_map_pkg::version_word;
      bus_map_pkg::addr_pat_aaaa: rd_word = bus_map_pkg::pat_aaaa_word;
      bus_map_pkg::addr_pat_5555: rd_word = bus_map_pkg::pat_5555_word;
      bus_map_pkg::addr_pat_ffff: rd_word = bus_map_pkg::pat_ffff_word;
      bus_map_pkg::addr_pat_0000: rd_word = bus_map_pkg::pat_0000_word;
      bus_map_pkg::addr_mode:     rd_word[num_pairs-1:0]   = limited;
      bus_map_pkg::addr_out_ctrl: rd_word[2*num_pairs-1:0] = ch_en;
      bus_map_pkg::addr_load:     rd_word[num_pairs-1:0]   = load_q;
      bus_map_pkg::addr_finished: rd_word[num_pairs-1:0]   = finished_q;
      default: ;
    endcase
    for (int n = 0; n < num_pairs; n++)
    begin
      if (la == pair_addr(bus_map_pkg::addr_freq_base, 4 * n))
        rd_word = freq[n][15:0];
      else if (la == pair_addr(bus_map_pkg::addr_freq_base, 4 * n + 2))
        rd_word = freq[n][31:16];
      else if (la == pair_addr(bus_map_pkg::addr_phase_base, 4 * n))
        rd_word = phase[n].raw[15:0];
      else if (la == pair_addr(bus_map_pkg::addr_phase_base, 4 * n + 2))
        rd_word = phase[n].raw[31:16];
      else if (la == pair_addr(bus_map_pkg::addr_pulse_base, 2 * n))
        rd_word = pulse_num[n];
    end
  end

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      rd_data    <= '0;
      finished_q <= '0;
    end
    else
    begin
      finished_q <= finished;  // one clock behind the pairs
      if (rd_stb)
        rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_sim_db.sv ====
`default_nettype none
`timescale 1ns/1ns

module tb_sim_db;

  localparam int num_pairs   = 2;
  localparam int n_regs      = 5 * num_pairs + 2;  // per-pair words plus mode and out_ctrl
  localparam int cycle_limit = 20000;              // several times the summed test length

  logic                   W_clk;
  logic                   W_reset_n;
  bus_map_pkg::addr_t     la;
  logic                   lcs_n;
  logic                   lrd_n;
  logic                   lwr_n;
  bus_map_pkg::reg_word_t ld_in;
  wire  [15:0]            ld_out;
  wire                    ld_oe;
  wire  [2*num_pairs-1:0] spd_ch;

  int                    err_cnt    = 0;
  int                    check_cnt  = 0;
  int                    cycle_cnt  = 0;
  logic [15:0]           lfsr_state = 16'd53173;
  tacho_pkg::pulse_cnt_t rise_cnt   = '0;  // rising edges of pair 0 channel 1
  logic                  ch1_prev   = 1'b0;

  sim_db_top #(
    .num_pairs (num_pairs)
  ) u_dut (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (la),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .ld_in     (ld_in),
    .ld_out    (ld_out),
    .ld_oe     (ld_oe),
    .spd_ch    (spd_ch)
  );

  always #10 W_clk = ~W_clk;

  always @(posedge W_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout: run stopped after %0d clocks", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  always @(negedge W_clk)
  begin
    ch1_prev <= spd_ch[0];
    if (spd_ch[0] && !ch1_prev)
      rise_cnt <= rise_cnt + 1'b1;
  end

  // ------------------------------------------------------------
  // compare tasks
  task automatic check_word(input string name, input bus_map_pkg::reg_word_t got, exp_v);
    check_cnt++;
    if (got !== exp_v)
    begin
      err_cnt++;
      $display("error %s: got %h expected %h", name, got, exp_v);
    end
  endtask

  task automatic check_ch(input string name, input logic [2*num_pairs-1:0] got, exp_v);
    check_cnt++;
    if (got !== exp_v)
    begin
      err_cnt++;
      $display("error %s: got %h expected %h", name, got, exp_v);
    end
  endtask

  task automatic check_count(input string name, input tacho_pkg::pulse_cnt_t got, exp_v);
    check_cnt++;
    if (got !== exp_v)
    begin
      err_cnt++;
      $display("error %s: got %h expected %h", name, got, exp_v);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp_v);
    check_cnt++;
    if (got !== exp_v)
    begin
      err_cnt++;
      $display("error %s: got %h expected %h", name, got, exp_v);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output bus_map_pkg::reg_word_t w);
    for (int i = 0; i < 16; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      w[i]       = lfsr_state[0];
    end
  endtask

  // ------------------------------------------------------------
  // local bus cycles with the strobe low at least 6 clocks
  task automatic bus_write(input bus_map_pkg::addr_t addr, input bus_map_pkg::reg_word_t data);
    @(posedge W_clk);
    la    <= addr;
    ld_in <= data;
    lcs_n <= 1'b0;
    lwr_n <= 1'b0;
    repeat (6) @(posedge W_clk);
    lwr_n <= 1'b1;
    lcs_n <= 1'b1;
    repeat (4) @(posedge W_clk);
  endtask

  task automatic bus_read(input bus_map_pkg::addr_t addr, output bus_map_pkg::reg_word_t data,
                          output logic oe);
    @(posedge W_clk);
    la    <= addr;
    lcs_n <= 1'b0;
    lrd_n <= 1'b0;
    repeat (6) @(posedge W_clk);
    @(negedge W_clk);  // data settled since the 4th clock
    data = ld_out;
    oe   = ld_oe;
    @(posedge W_clk);
    lrd_n <= 1'b1;
    lcs_n <= 1'b1;
    repeat (4) @(posedge W_clk);
  endtask

  task automatic set_pair(input int n, input tacho_pkg::acc_t freq,
                          input tacho_pkg::phase_word_u phase, input tacho_pkg::pulse_cnt_t pulses);
    bus_write(bus_map_pkg::addr_freq_base + 12'(4 * n), freq[15:0]);
    bus_write(bus_map_pkg::addr_freq_base + 12'(4 * n + 2), freq[31:16]);
    bus_write(bus_map_pkg::addr_phase_base + 12'(4 * n), phase.raw[15:0]);
    bus_write(bus_map_pkg::addr_phase_base + 12'(4 * n + 2), phase.raw[31:16]);
    bus_write(bus_map_pkg::addr_pulse_base + 12'(2 * n), pulses);
  endtask

  task automatic restart_pair(input int n);
    bus_write(bus_map_pkg::addr_load, 16'h0000);
    bus_write(bus_map_pkg::addr_load, 16'h0001 << n);  // 0 -> 1 edge
  endtask

  // collects which channels were high and which changed
  task automatic watch(input int cycles, output logic [2*num_pairs-1:0] seen,
                       output logic [2*num_pairs-1:0] toggled);
    logic [2*num_pairs-1:0] prev;
    @(negedge W_clk);
    prev    = spd_ch;
    seen    = spd_ch;
    toggled = '0;
    repeat (cycles)
    begin
      @(negedge W_clk);
      seen    = seen | spd_ch;
      toggled = toggled | (spd_ch ^ prev);
      prev    = spd_ch;
    end
  endtask

  // polls the finished register until bit n is set, then checks the pulse count
  task automatic count_run(input int n, input tacho_pkg::pulse_cnt_t snap,
                           input tacho_pkg::pulse_cnt_t exp_pulses);
    bus_map_pkg::reg_word_t rd;
    logic                   oe;
    int                     polls;
    polls = 0;
    rd    = '0;
    while (!rd[n] && polls < 40)
    begin
      bus_read(bus_map_pkg::addr_finished, rd, oe);
      polls++;
    end
    if (!rd[n])
    begin
      err_cnt++;
      $display("finished flag of pair %0d was never raised", n);
    end
    check_count("spd_ch[0] rising edges", rise_cnt - snap, exp_pulses);
  endtask

  // ------------------------------------------------------------
  // directed tests
  task automatic reset_values();
    bus_map_pkg::reg_word_t rd;
    logic                   oe;
    @(negedge W_clk);
    check_flag("ld_oe", ld_oe, 1'b0);
    check_ch("spd_ch", spd_ch, '0);
    bus_read(bus_map_pkg::addr_version, rd, oe);
    check_word("ld_out @800", rd, 16'hB626);
    check_flag("ld_oe", oe, 1'b1);
    bus_read(bus_map_pkg::addr_pat_aaaa, rd, oe);
    check_word("ld_out @802", rd, 16'hAAAA);
    bus_read(bus_map_pkg::addr_pat_5555, rd, oe);
    check_word("ld_out @804", rd, 16'h5555);
    bus_read(bus_map_pkg::addr_pat_ffff, rd, oe);
    check_word("ld_out @806", rd, 16'hFFFF);
    bus_read(bus_map_pkg::addr_pat_0000, rd, oe);
    check_word("ld_out @808", rd, 16'h0000);
    bus_read(12'h400, rd, oe);  // outside the 0x8xx window
    check_flag("ld_oe", oe, 1'b0);
  endtask

  task automatic register_access();
    bus_map_pkg::addr_t     addr [n_regs];
    bus_map_pkg::reg_word_t exp_w [n_regs];
    bus_map_pkg::reg_word_t mask;
    bus_map_pkg::reg_word_t rd;
    logic                   oe;
    for (int n = 0; n < num_pairs; n++)
    begin
      addr[5*n]   = bus_map_pkg::addr_freq_base + 12'(4 * n);
      addr[5*n+1] = bus_map_pkg::addr_freq_base + 12'(4 * n + 2);
      addr[5*n+2] = bus_map_pkg::addr_phase_base + 12'(4 * n);
      addr[5*n+3] = bus_map_pkg::addr_phase_base + 12'(4 * n + 2);
      addr[5*n+4] = bus_map_pkg::addr_pulse_base + 12'(2 * n);
    end
    addr[n_regs-2] = bus_map_pkg::addr_mode;
    addr[n_regs-1] = bus_map_pkg::addr_out_ctrl;
    for (int i = 0; i < n_regs; i++)
    begin
      random_word(exp_w[i]);
      bus_write(addr[i], exp_w[i]);
      mask = 16'hFFFF;
      if (addr[i] == bus_map_pkg::addr_mode)
        mask = (16'h1 << num_pairs) - 1'b1;  // one bit per pair
      else if (addr[i] == bus_map_pkg::addr_out_ctrl)
        mask = (16'h1 << (2 * num_pairs)) - 1'b1;
      exp_w[i] = exp_w[i] & mask;
    end
    for (int i = 0; i < n_regs; i++)
    begin
      bus_read(addr[i], rd, oe);
      check_word($sformatf("ld_out @%h", addr[i]), rd, exp_w[i]);
    end
    // quiet all pairs, then the finished word must stay zero
    bus_write(bus_map_pkg::addr_mode, 16'h0000);
    bus_write(bus_map_pkg::addr_out_ctrl, 16'h0000);
    bus_write(bus_map_pkg::addr_load, 16'h0000);
    bus_write(bus_map_pkg::addr_load, (16'h1 << num_pairs) - 1'b1);
    bus_write(bus_map_pkg::addr_finished, 16'hFFFF);
    bus_read(bus_map_pkg::addr_finished, rd, oe);
    check_word("ld_out @870", rd, 16'h0000);
  endtask

  task automatic output_gating();
    tacho_pkg::phase_word_u ph;
    logic [2*num_pairs-1:0] seen;
    logic [2*num_pairs-1:0] toggled;
    ph.raw = '0;
    set_pair(0, 32'h0400_0000, ph, 16'd0);
    set_pair(1, 32'h0400_0000, ph, 16'd0);
    restart_pair(0);
    watch(200, seen, toggled);
    check_ch("spd_ch disabled", seen, '0);
    bus_write(bus_map_pkg::addr_out_ctrl, 16'h0003);
    watch(200, seen, toggled);
    check_ch("spd_ch toggled", toggled, 4'b0011);
    bus_write(bus_map_pkg::addr_out_ctrl, 16'h000C);  // pair 1 only
    watch(200, seen, toggled);
    check_ch("spd_ch toggled", toggled, 4'b1100);
    bus_write(bus_map_pkg::addr_out_ctrl, 16'h0003);
  endtask

  task automatic phase_lead(input logic leads);
    tacho_pkg::phase_word_u ph;
    int                     waited;
    ph.fields.ch2_leads = leads;
    ph.fields.offset    = 31'h4000_0000;  // quarter period
    set_pair(0, 32'h0100_0000, ph, 16'd0);
    restart_pair(0);
    waited = 0;
    @(negedge W_clk);
    while (spd_ch[1:0] == 2'b00 && waited < 400)
    begin
      @(negedge W_clk);
      waited++;
    end
    if (spd_ch[1:0] == 2'b00)
    begin
      err_cnt++;
      $display("no channel of pair 0 rose after the load");
    end
    else
      check_ch("spd_ch first rise", spd_ch, leads ? 4'b0010 : 4'b0001);
  endtask

  task automatic limited_run();
    tacho_pkg::phase_word_u ph;
    tacho_pkg::pulse_cnt_t  snap;
    bus_map_pkg::reg_word_t rd;
    logic                   oe;
    logic [2*num_pairs-1:0] seen;
    logic [2*num_pairs-1:0] toggled;
    ph.raw = '0;
    set_pair(0, 32'h0800_0000, ph, 16'd5);
    bus_write(bus_map_pkg::addr_mode, 16'h0001);
    restart_pair(0);
    snap = rise_cnt;
    count_run(0, snap, 16'd5);
    bus_read(bus_map_pkg::addr_finished, rd, oe);
    check_word("ld_out @870", rd, 16'h0001);
    watch(300, seen, toggled);
    check_ch("spd_ch after run", seen, '0);
    // zero count finishes at once
    bus_write(bus_map_pkg::addr_pulse_base, 16'd0);
    restart_pair(0);
    snap = rise_cnt;
    count_run(0, snap, 16'd0);
    watch(100, seen, toggled);
    check_ch("spd_ch zero count", seen, '0);
  endtask

  task automatic reload_run();
    tacho_pkg::pulse_cnt_t  snap;
    bus_map_pkg::reg_word_t rd;
    logic                   oe;
    bus_write(bus_map_pkg::addr_pulse_base, 16'd5);
    restart_pair(0);
    snap = rise_cnt;
    bus_read(bus_map_pkg::addr_finished, rd, oe);
    check_word("ld_out @870", rd, 16'h0000);
    count_run(0, snap, 16'd5);
  endtask

  // ------------------------------------------------------------
  initial
  begin
    W_clk     = 1'b0;
    W_reset_n = 1'b0;
    la        = '0;
    lcs_n     = 1'b1;
    lrd_n     = 1'b1;
    lwr_n     = 1'b1;
    ld_in     = '0;
    repeat (5) @(posedge W_clk);
    W_reset_n <= 1'b1;
    @(posedge W_clk);
    reset_values();
    register_access();
    output_gating();
    phase_lead(1'b1);
    phase_lead(1'b0);
    limited_run();
    reload_run();
    $display("checks %0d, errors %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
